// File: dp_pkg.sv
`default_nettype none

package dp_pkg;

    localparam int unsigned N_SRC     = 24;
    localparam int unsigned RAM_WORDS = 512;
    localparam int unsigned RAM_AW    = 9;

    typedef logic [31:0] word_t;

    // Load instruction sits at this address
    localparam word_t PC_INIT = 32'd6;

    typedef enum logic [4:0] {
        add, sub, and_op, or_op,
        shr, shra, shl, ror, rol,
        mul, div,
        neg, not_op
    } alu_op_e;

    // Bus sources, lowest index has priority
    typedef enum logic [4:0] {
        src_r0, src_r1, src_r2, src_r3, src_r4, src_r5, src_r6, src_r7,
        src_r8, src_r9, src_r10, src_r11, src_r12, src_r13, src_r14, src_r15,
        src_hi, src_lo, src_zhi, src_zlo, src_pc, src_mdr, src_inport, src_csign
    } bus_src_e;

    typedef logic [N_SRC-1:0] src_mask_t;

    typedef struct packed {
        src_mask_t   src_mask;
        logic [15:0] reg_en;
        logic        hi_en;
        logic        lo_en;
        logic        y_en;
        logic        z_en;
        logic        ir_en;
        logic        pc_en;
        logic        mar_en;
        logic        mdr_en;
        logic        con_in;
        logic        out_en;
        logic        inc_pc;
        logic        read;
        logic        ram_write;
        logic        ba_out;
    } ctrl_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } z_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic          clk,
    input  logic          rst_n,
    input  dp_pkg::word_t bus,
    input  logic [15:0]   reg_en,
    input  logic          ba_out,
    output dp_pkg::word_t regs [16]
);

    import dp_pkg::*;

    word_t r_q [16];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                r_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (reg_en[i]) begin
                    r_q[i] <= bus;
                end
            end
        end
    end

    // R0 reads as zero for base-address calculations
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            regs[i] = r_q[i];
        end
        if (ba_out) begin
            regs[0] = '0;
        end
    end

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  dp_pkg::src_mask_t src_mask,
    input  dp_pkg::word_t     regs [16],
    input  dp_pkg::word_t     hi,
    input  dp_pkg::word_t     lo,
    input  dp_pkg::word_t     pc,
    input  dp_pkg::word_t     mdr,
    input  dp_pkg::word_t     inport,
    input  dp_pkg::word_t     csign,
    input  dp_pkg::z_t        z,
    output dp_pkg::word_t     bus
);

    import dp_pkg::*;

    bus_src_e grant;
    logic     grant_vld;
    word_t    sel_word;

    // Scan downwards so the lowest raised strobe is kept
    always_comb begin
        grant     = src_r0;
        grant_vld = 1'b0;
        for (int i = N_SRC - 1; i >= 0; i--) begin
            if (src_mask[i]) begin
                grant     = bus_src_e'(i);
                grant_vld = 1'b1;
            end
        end
    end

    always_comb begin
        case (grant)
            src_hi:     sel_word = hi;
            src_lo:     sel_word = lo;
            src_zhi:    sel_word = z.hi;
            src_zlo:    sel_word = z.lo;
            src_pc:     sel_word = pc;
            src_mdr:    sel_word = mdr;
            src_inport: sel_word = inport;
            src_csign:  sel_word = csign;
            default:    sel_word = regs[grant[3:0]];
        endcase
    end

    // Idle bus reads as zero
    assign bus = grant_vld ? sel_word : '0;

endmodule

`default_nettype wire

// File: alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  dp_pkg::word_t   bus,
    input  logic            y_en,
    input  logic            z_en,
    input  dp_pkg::alu_op_e opcode,
    output dp_pkg::z_t      z
);

    import dp_pkg::*;

    word_t              y_q;
    z_t                 z_q;
    z_t                 res;
    logic [4:0]         amt;
    logic signed [63:0] prod;

    assign amt  = bus[4:0];
    assign prod = $signed(y_q) * $signed(bus);

    always_comb begin
        res = '0;
        case (opcode)
            add:    res.lo = y_q + bus;
            sub:    res.lo = y_q - bus;
            and_op: res.lo = y_q & bus;
            or_op:  res.lo = y_q | bus;
            shr:    res.lo = y_q >> amt;
            shra:   res.lo = $signed(y_q) >>> amt;
            shl:    res.lo = y_q << amt;
            ror:    res.lo = y_q >> amt | y_q << (6'd32 - {1'b0, amt});
            rol:    res.lo = y_q << amt | y_q >> (6'd32 - {1'b0, amt});
            mul:    res    = prod;
            div: begin
                // Divide by zero leaves both halves clear
                if (bus != '0) begin
                    res.lo = $signed(y_q) / $signed(bus);
                    res.hi = $signed(y_q) % $signed(bus);
                end
            end
            // Unary ops work on the bus operand
            neg:    res.lo = -bus;
            not_op: res.lo = ~bus;
            default: res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_q <= '0;
            z_q <= '0;
        end else begin
            if (y_en) begin
                y_q <= bus;
            end
            if (z_en) begin
                z_q <= res;
            end
        end
    end

    assign z = z_q;

endmodule

`default_nettype wire

// File: mem_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  dp_pkg::word_t bus,
    input  logic          mar_en,
    input  logic          mdr_en,
    input  logic          read,
    input  logic          ram_write,
    output dp_pkg::word_t mdr
);

    import dp_pkg::*;

    // Only the address bits the RAM decodes are kept
    logic [RAM_AW-1:0] mar_q;
    word_t             mdr_q;
    word_t             ram_rdata;
    word_t             ram [RAM_WORDS];

    assign ram_rdata = ram[mar_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar_q <= '0;
            mdr_q <= '0;
        end else begin
            if (mar_en) begin
                mar_q <= bus[RAM_AW-1:0];
            end
            if (mdr_en) begin
                mdr_q <= read ? ram_rdata : bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_write) begin
            ram[mar_q] <= mdr_q;
        end
    end

    assign mdr = mdr_q;

endmodule

`default_nettype wire

// File: special_regs.sv
`timescale 1ns/1ns
`default_nettype none

module special_regs (
    input  logic          clk,
    input  logic          rst_n,
    input  dp_pkg::word_t bus,
    input  logic          hi_en,
    input  logic          lo_en,
    input  logic          ir_en,
    input  logic          pc_en,
    input  logic          inc_pc,
    input  logic          con_in,
    input  logic          out_en,
    input  dp_pkg::word_t in_port_data,
    output dp_pkg::word_t hi,
    output dp_pkg::word_t lo,
    output dp_pkg::word_t pc,
    output dp_pkg::word_t inport,
    output dp_pkg::word_t csign,
    output dp_pkg::word_t out_port,
    output logic          con
);

    import dp_pkg::*;

    word_t       pc_q;
    word_t       hi_q;
    word_t       lo_q;
    word_t       in_q;
    word_t       out_q;
    // Opcode and register fields are decoded outside the datapath
    logic [20:0] ir_q;
    logic        con_q;
    logic        cond_met;

    always_comb begin
        case (ir_q[20:19])
            2'b00:   cond_met = (bus == '0);
            2'b01:   cond_met = (bus != '0);
            2'b10:   cond_met = !bus[31] && (bus != '0);
            default: cond_met = bus[31];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q  <= PC_INIT;
            ir_q  <= '0;
            hi_q  <= '0;
            lo_q  <= '0;
            in_q  <= '0;
            out_q <= '0;
            con_q <= 1'b0;
        end else begin
            // Bus load wins over increment
            if (pc_en) begin
                pc_q <= bus;
            end else if (inc_pc) begin
                pc_q <= pc_q + 32'd1;
            end
            if (ir_en) begin
                ir_q <= bus[20:0];
            end
            if (hi_en) begin
                hi_q <= bus;
            end
            if (lo_en) begin
                lo_q <= bus;
            end
            if (out_en) begin
                out_q <= bus;
            end
            if (con_in) begin
                con_q <= cond_met;
            end
            in_q <= in_port_data;
        end
    end

    assign pc       = pc_q;
    assign hi       = hi_q;
    assign lo       = lo_q;
    assign inport   = in_q;
    assign out_port = out_q;
    assign con      = con_q;
    assign csign    = {{13{ir_q[18]}}, ir_q[18:0]};

endmodule

`default_nettype wire

// File: datapath_top.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_top (
    input  logic            clk,
    input  logic            rst_n,
    input  dp_pkg::ctrl_t   ctrl,
    input  dp_pkg::alu_op_e opcode,
    input  dp_pkg::word_t   in_port_data,
    output dp_pkg::word_t   bus,
    output dp_pkg::word_t   out_port,
    output logic            con
);

    import dp_pkg::*;

    word_t regs [16];
    word_t hi;
    word_t lo;
    word_t pc;
    word_t mdr;
    word_t inport;
    word_t csign;
    z_t    z;

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .reg_en (ctrl.reg_en),
        .ba_out (ctrl.ba_out),
        .regs   (regs)
    );

    alu_unit i_alu_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .y_en   (ctrl.y_en),
        .z_en   (ctrl.z_en),
        .opcode (opcode),
        .z      (z)
    );

    mem_unit i_mem_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .mar_en    (ctrl.mar_en),
        .mdr_en    (ctrl.mdr_en),
        .read      (ctrl.read),
        .ram_write (ctrl.ram_write),
        .mdr       (mdr)
    );

    special_regs i_special_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus),
        .hi_en        (ctrl.hi_en),
        .lo_en        (ctrl.lo_en),
        .ir_en        (ctrl.ir_en),
        .pc_en        (ctrl.pc_en),
        .inc_pc       (ctrl.inc_pc),
        .con_in       (ctrl.con_in),
        .out_en       (ctrl.out_en),
        .in_port_data (in_port_data),
        .hi           (hi),
        .lo           (lo),
        .pc           (pc),
        .inport       (inport),
        .csign        (csign),
        .out_port     (out_port),
        .con          (con)
    );

    bus_arbiter i_bus_arbiter (
        .src_mask (ctrl.src_mask),
        .regs     (regs),
        .hi       (hi),
        .lo       (lo),
        .pc       (pc),
        .mdr      (mdr),
        .inport   (inport),
        .csign    (csign),
        .z        (z),
        .bus      (bus)
    );

endmodule

`default_nettype wire

// File: datapath_checker.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_checker (
    input logic          clk,
    input logic          rst_n,
    input dp_pkg::ctrl_t ctrl,
    input dp_pkg::word_t bus,
    input dp_pkg::word_t out_port,
    input logic          con
);

    // Set once any assertion below has failed
    logic fail_seen;

    initial begin
        fail_seen = 1'b0;
    end

    // con only moves one edge after its load strobe
    a_con_load: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(con) |-> $past(ctrl.con_in))
        else begin
            $error("con changed without con_in in the previous cycle");
            fail_seen = 1'b1;
        end

    a_out_load: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(out_port) |-> $past(ctrl.out_en))
        else begin
            $error("out_port changed without out_en in the previous cycle");
            fail_seen = 1'b1;
        end

    // Idle bus
    a_bus_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.src_mask == '0) |-> (bus == '0))
        else begin
            $error("bus not zero while no source strobe is raised");
            fail_seen = 1'b1;
        end

endmodule

bind datapath_top datapath_checker i_datapath_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .bus      (bus),
    .out_port (out_port),
    .con      (con)
);

`default_nettype wire

// File: tb_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module tb_datapath;

    import dp_pkg::*;

    logic    clk;
    logic    rst_n;
    ctrl_t   ctrl;
    alu_op_e opcode;
    word_t   in_port_data;
    word_t   bus;
    word_t   out_port;
    logic    con;

    datapath_top i_datapath_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .opcode       (opcode),
        .in_port_data (in_port_data),
        .bus          (bus),
        .out_port     (out_port),
        .con          (con)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // Bound assertions flag their failures here
    always @(posedge clk) begin
        if (i_datapath_top.i_datapath_checker.fail_seen) begin
            stop_run("an assertion in datapath_checker failed");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                stop_run("reset was not released within 20 cycles");
            end
        end
    endtask

    function automatic ctrl_t src_ctrl(input bus_src_e s);
        ctrl_t c;
        c = '0;
        c.src_mask[s] = 1'b1;
        return c;
    endfunction

    task automatic apply(input ctrl_t c);
        @(posedge clk);
        ctrl <= c;
        @(negedge clk);
    endtask

    // Word enters through the input port, then goes over the bus to dest
    task automatic put_word(input word_t v, input ctrl_t dest);
        ctrl_t c;
        c = dest;
        c.src_mask[src_inport] = 1'b1;
        @(posedge clk);
        ctrl <= '0;
        in_port_data <= v;
        @(posedge clk);
        ctrl <= c;
        @(negedge clk);
        check_word("bus", bus, v);
    endtask

    task automatic read_src(input bus_src_e s, input word_t exp);
        apply(src_ctrl(s));
        check_word("bus", bus, exp);
    endtask

    function automatic z_t alu_expect(input alu_op_e op, input word_t a, input word_t b);
        z_t r;
        int unsigned n;
        longint p;
        r = '0;
        n = b[4:0];
        case (op)
            add:    r.lo = a + b;
            sub:    r.lo = a + ~b + 32'd1;
            and_op: r.lo = a & b;
            or_op:  r.lo = a | b;
            shr:    r.lo = a >> n;
            shra: begin
                r.lo = a >> n;
                if (a[31]) begin
                    r.lo = r.lo | ~(32'hffff_ffff >> n);
                end
            end
            shl:    r.lo = a << n;
            ror: begin
                r.lo = a;
                repeat (n) r.lo = {r.lo[0], r.lo[31:1]};
            end
            rol: begin
                r.lo = a;
                repeat (n) r.lo = {r.lo[30:0], r.lo[31]};
            end
            mul: begin
                p = longint'(int'(a)) * longint'(int'(b));
                r = p;
            end
            div: begin
                if (b != 0) begin
                    r.lo = int'(a) / int'(b);
                    r.hi = int'(a) % int'(b);
                end
            end
            neg:    r.lo = 32'd0 - b;
            not_op: r.lo = b ^ 32'hffff_ffff;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic cond_expect(input logic [1:0] cc, input word_t v);
        case (cc)
            2'b00:   return v == 0;
            2'b01:   return v != 0;
            2'b10:   return int'(v) > 0;
            default: return int'(v) < 0;
        endcase
    endfunction

    task automatic test_reset();
        apply('0);
        check_word("bus", bus, '0);
        check_word("out_port", out_port, '0);
        check_bit("con", con, 1'b0);
        read_src(src_pc, PC_INIT);
    endtask

    task automatic test_regs();
        word_t exp [16];
        ctrl_t c;
        for (int i = 1; i < 16; i++) begin
            exp[i] = $urandom;
            c = '0;
            c.reg_en[i] = 1'b1;
            put_word(exp[i], c);
        end
        for (int i = 1; i < 16; i++) begin
            read_src(bus_src_e'(i), exp[i]);
        end
        c = src_ctrl(src_r3);
        c.src_mask[src_r9] = 1'b1;
        c.src_mask[src_hi] = 1'b1;
        apply(c);
        check_word("bus", bus, exp[3]);
        c = '0;
        c.reg_en[0] = 1'b1;
        put_word(32'hcafe_0042, c);
        read_src(src_r0, 32'hcafe_0042);
        // Base-address mode hides R0 even with R5 also raised
        c = src_ctrl(src_r0);
        c.src_mask[src_r5] = 1'b1;
        c.ba_out = 1'b1;
        apply(c);
        check_word("bus", bus, '0);
    endtask

    task automatic test_alu();
        ctrl_t cy;
        ctrl_t cz;
        alu_op_e op;
        word_t a;
        word_t b;
        z_t exp;
        cy = '0;
        cy.y_en = 1'b1;
        cz = '0;
        cz.z_en = 1'b1;
        for (int k = 0; k < 13; k++) begin
            op = alu_op_e'(k);
            for (int t = 0; t < 4; t++) begin
                a = $urandom;
                b = $urandom;
                if (op == div && t == 0) begin
                    b = '0;
                end
                exp = alu_expect(op, a, b);
                @(posedge clk);
                ctrl <= '0;
                opcode <= op;
                put_word(a, cy);
                put_word(b, cz);
                read_src(src_zlo, exp.lo);
                read_src(src_zhi, exp.hi);
            end
        end
    endtask

    task automatic test_memory();
        logic [RAM_AW-1:0] addr [8];
        word_t data [8];
        ctrl_t c;
        int unsigned base;
        base = $urandom % RAM_WORDS;
        for (int i = 0; i < 8; i++) begin
            addr[i] = (base + i * 37) % RAM_WORDS;
            data[i] = $urandom;
            c = '0;
            c.mar_en = 1'b1;
            put_word(32'(addr[i]), c);
            c = '0;
            c.mdr_en = 1'b1;
            put_word(data[i], c);
            c = '0;
            c.ram_write = 1'b1;
            apply(c);
            apply('0);
        end
        for (int i = 0; i < 8; i++) begin
            c = '0;
            c.mar_en = 1'b1;
            put_word(32'(addr[i]), c);
            c = '0;
            c.mdr_en = 1'b1;
            c.read = 1'b1;
            apply(c);
            read_src(src_mdr, data[i]);
        end
    endtask

    task automatic test_control();
        ctrl_t c;
        word_t v;
        word_t vals [4];
        read_src(src_pc, PC_INIT);
        c = '0;
        c.inc_pc = 1'b1;
        repeat (3) apply(c);
        read_src(src_pc, PC_INIT + 3);
        v = $urandom;
        c = '0;
        c.pc_en = 1'b1;
        put_word(v, c);
        read_src(src_pc, v);
        // Load takes precedence over increment
        v = $urandom;
        c.inc_pc = 1'b1;
        put_word(v, c);
        read_src(src_pc, v);
        c = '0;
        c.inc_pc = 1'b1;
        apply(c);
        read_src(src_pc, v + 1);

        v = $urandom;
        c = '0;
        c.hi_en = 1'b1;
        put_word(v, c);
        read_src(src_hi, v);
        c = '0;
        c.lo_en = 1'b1;
        put_word(~v, c);
        read_src(src_lo, ~v);
        read_src(src_hi, v);

        c = '0;
        c.ir_en = 1'b1;
        for (int i = 0; i < 4; i++) begin
            v = $urandom;
            if (i == 0) begin
                v[18] = 1'b1;
            end
            put_word(v, c);
            read_src(src_csign, word_t'(int'(v << 13) >>> 13));
        end

        vals[0] = '0;
        vals[1] = 32'h0000_1234;
        vals[2] = 32'h8000_0010;
        vals[3] = $urandom;
        for (int cc = 0; cc < 4; cc++) begin
            c = '0;
            c.ir_en = 1'b1;
            put_word(32'(cc) << 19, c);
            for (int i = 0; i < 4; i++) begin
                c = '0;
                c.con_in = 1'b1;
                put_word(vals[i], c);
                apply('0);
                check_bit("con", con, cond_expect(2'(cc), vals[i]));
            end
        end

        v = $urandom;
        c = '0;
        c.out_en = 1'b1;
        put_word(v, c);
        apply('0);
        check_word("out_port", out_port, v);
        put_word(~v, '0);
        apply('0);
        check_word("out_port", out_port, v);
    endtask

    initial begin
        ctrl = '0;
        opcode = add;
        in_port_data = '0;
        void'($urandom(32'h5063));
        wait_reset_release();
        test_reset();
        test_regs();
        test_alu();
        test_memory();
        test_control();
        apply('0);
        if (i_datapath_top.i_datapath_checker.fail_seen) begin
            stop_run("an assertion in datapath_checker failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
dp_pkg.sv
reg_file.sv
bus_arbiter.sv
alu_unit.sv
mem_unit.sv
special_regs.sv
datapath_top.sv
datapath_checker.sv
tb_datapath.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - dp_pkg.sv
  - reg_file.sv
  - bus_arbiter.sv
  - alu_unit.sv
  - mem_unit.sv
  - special_regs.sv
  - datapath_top.sv
  - target: simulation
    files:
      - datapath_checker.sv
      - tb_datapath.sv
